/* src.f */
+incdir+verification
design/chip8_isa_pkg.sv
design/chip8_core_pkg.sv
design/chip8_memory.sv
design/instr_decoder.sv
design/register_file.sv
design/chip8_alu.sv
design/call_stack.sv
design/chip8_sequencer.sv
design/chip8_top.sv
verification/tb_clock_gen.sv
verification/chip8_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module chip8_tb -o chip8_sim \
   && ./obj_dir/chip8_sim > sim.log 2>&1
grep -q "^TB PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verification/chip8_ref_model.svh */
`ifndef CHIP8_REF_MODEL_SVH
`define CHIP8_REF_MODEL_SVH

   logic [15:0] prog_words [$]; // all test programs back to back
   int          prog_base [6];
   int          built_tests;
   logic [7:0]  ref_regs [16];
   logic [7:0]  ref_mem [4096];
   logic [11:0] ref_stack [$];

   function automatic logic [7:0] rand_byte();
      return 8'($urandom);
   endfunction

   function automatic void emit(input logic [15:0] word);
      prog_words.push_back(word);
   endfunction

   // closes the current program with a jump to itself
   function automatic void end_program();
      logic [11:0] self_addr;
      self_addr = PROGRAM_START + 12'(2 * (prog_words.size() - prog_base[built_tests]));
      emit({4'h1, self_addr});
      built_tests++;
      prog_base[built_tests] = prog_words.size();
   endfunction

   function automatic void build_after_reset();
      emit(16'h00E0); // screen clear retires as a nop
      emit({8'h63, rand_byte()});
      emit(16'hE39E); // key skip is a nop
      emit({8'hC3, rand_byte()}); // random is a nop
      end_program();
   endfunction

   function automatic void build_immediates();
      emit(16'h65F0);
      emit(16'h7535); // wraps past 0xFF
      for (int n = 0; n < 14; n++)
         emit({($urandom_range(1) == 0) ? 4'h6 : 4'h7, 4'($urandom_range(15)), rand_byte()});
      end_program();
   endfunction

   function automatic void build_alu();
      logic [3:0] ops [9];
      logic [3:0] x;
      logic [3:0] y;
      ops = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
      foreach (ops[k])
      begin
         x = 4'($urandom_range(14));
         y = 4'((int'(x) + 1 + $urandom_range(13)) % 15); // distinct from x and never vf
         emit({4'h6, x, rand_byte()});
         emit({4'h6, y, rand_byte()});
         emit({4'h8, x, y, ops[k]});
      end
      end_program();
   endfunction

   // every skip kind goes both ways before the call at 21E
   // return lands on 220 and BNNN then jumps to 22E
   function automatic void build_control();
      logic [15:0] flow [25];
      flow = '{16'h615A, 16'h315A, 16'h6E01, 16'h3100, 16'h415A, 16'h4100, 16'h6E02,
               16'h625A, 16'h5120, 16'h6E03, 16'h9120, 16'h6200, 16'h5120, 16'h9120,
               16'h6E04, 16'h2226, 16'h6004, 16'hB22A, 16'h0000, 16'h00EE, 16'h6E05,
               16'h6E06, 16'h6E07, 16'h1232, 16'h6E08};
      foreach (flow[k])
         emit(flow[k]);
      end_program();
   endfunction

   function automatic void build_memory();
      for (int n = 0; n < 6; n++)
         emit({4'h6, 4'(n), rand_byte()});
      emit({8'hA3, rand_byte()}); // I somewhere in 0x300..0x3FF
      emit({12'h6E0, 4'($urandom_range(15))});
      emit(16'hFE1E);
      emit(16'hF555);
      for (int n = 0; n < 6; n++)
         emit({4'h6, 4'(n), 8'h00});
      emit(16'hF565);
      emit({8'h60, rand_byte()}); // single byte store and reload
      emit(16'hA3F0);
      emit(16'hF055);
      emit(16'h6000);
      emit(16'hF065);
      end_program();
   endfunction

   function automatic void write_reg(input logic [3:0] index, input logic [7:0] value);
      ref_regs[index] = value;
      exp_reg.push_back(32'({index, value}));
   endfunction

   function automatic void alu_step(input logic [3:0] x, input logic [3:0] kind,
                                    input logic [7:0] vx, input logic [7:0] vy);
      logic [7:0] res;
      logic       flag;
      logic       writes_flag;
      writes_flag = kind inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
      flag = 1'b0;
      case (kind)
         4'h0: res = vy;
         4'h1: res = vx | vy;
         4'h2: res = vx & vy;
         4'h3: res = vx ^ vy;
         4'h4: {flag, res} = {1'b0, vx} + {1'b0, vy};
         4'h5:
         begin
            res = vx - vy;
            flag = (vx >= vy);
         end
         4'h6:
         begin
            res = vx >> 1;
            flag = vx[0];
         end
         4'h7:
         begin
            res = vy - vx;
            flag = (vy >= vx);
         end
         4'hE:
         begin
            res = vx << 1;
            flag = vx[7];
         end
         default: return; // undefined 8XY_ is a nop
      endcase
      write_reg(x, res);
      if (writes_flag)
         write_reg(4'hF, {7'b0, flag}); // vf always after the result
   endfunction

   // runs one test program and fills the expected event queues
   function automatic void interpret(input int test);
      logic [15:0] w;
      logic [11:0] pc;
      logic [11:0] i_reg;
      logic [11:0] target;
      logic [7:0]  vx;
      logic [7:0]  vy;
      int          addr;
      exp_reg.delete();
      exp_mem.delete();
      exp_ret.delete();
      ref_stack.delete();
      foreach (ref_regs[r])
         ref_regs[r] = 8'h00;
      foreach (ref_mem[a])
         ref_mem[a] = 8'h00;
      for (int k = prog_base[test]; k < prog_base[test + 1]; k++)
      begin
         addr = int'(PROGRAM_START) + 2 * (k - prog_base[test]);
         ref_mem[addr] = prog_words[k][15:8];
         ref_mem[addr + 1] = prog_words[k][7:0];
      end
      pc = PROGRAM_START;
      i_reg = '0;
      for (int step = 0; step < 1000; step++)
      begin
         w = {ref_mem[pc], ref_mem[pc + 12'd1]};
         vx = ref_regs[w[11:8]];
         vy = ref_regs[w[7:4]];
         exp_ret.push_back(32'(pc));
         if (w[15:12] == 4'h1 && w[11:0] == pc)
            break; // self jump ends the program
         target = pc + 12'd2;
         case (w[15:12])
            4'h0: if (w == 16'h00EE) target = ref_stack.pop_back();
            4'h1: target = w[11:0];
            4'h2:
            begin
               ref_stack.push_back(pc + 12'd2);
               target = w[11:0];
            end
            4'h3: if (vx == w[7:0]) target = pc + 12'd4;
            4'h4: if (vx != w[7:0]) target = pc + 12'd4;
            4'h5: if (w[3:0] == 4'h0 && vx == vy) target = pc + 12'd4;
            4'h6: write_reg(w[11:8], w[7:0]);
            4'h7: write_reg(w[11:8], vx + w[7:0]);
            4'h8: alu_step(w[11:8], w[3:0], vx, vy);
            4'h9: if (w[3:0] == 4'h0 && vx != vy) target = pc + 12'd4;
            4'hA: i_reg = w[11:0];
            4'hB: target = w[11:0] + 12'(ref_regs[0]);
            4'hF:
            begin
               if (w[7:0] == 8'h1E)
                  i_reg = i_reg + 12'(vx);
               for (int r = 0; r <= int'(w[11:8]); r++)
               begin
                  if (w[7:0] == 8'h55)
                  begin
                     ref_mem[i_reg + 12'(r)] = ref_regs[r];
                     exp_mem.push_back(32'({i_reg + 12'(r), ref_regs[r]}));
                  end
                  else if (w[7:0] == 8'h65)
                     write_reg(4'(r), ref_mem[i_reg + 12'(r)]);
               end
            end
            default: ; // dropped classes retire as nops
         endcase
         pc = target;
      end
   endfunction

`endif

/* verification/chip8_tb.sv */
`timescale 1ns/10ps

module chip8_tb import chip8_isa_pkg::*, chip8_core_pkg::*;
();

   localparam int NUM_TESTS        = 5;
   localparam int RESET_CYCLES     = 5;
   localparam int CYCLES_PER_INSTR = 40;

   logic                  clk;
   logic                  reset;
   logic                  rx_valid;
   logic                  run;
   logic [DATA_WIDTH-1:0] rx_data;
   reg_wr_t               reg_wr;
   mem_wr_t               mem_wr;
   retire_t               retire;

   logic [31:0] exp_reg [$];
   logic [31:0] exp_mem [$];
   logic [31:0] exp_ret [$];
   logic [31:0] end_pc;
   logic [31:0] first_pc;
   logic        finished;
   logic        first_seen;
   int          phase; // 0 ignore, 1 loading, 2 running
   int          test_errors;
   int          total_errors;
   int          failed_tests;
   int          watchdog_cycles;
   string       test_name;

   `include "chip8_ref_model.svh"

   tb_clock_gen tb_clock_gen_i (.clk(clk));

   chip8_top chip8_top_i (
      .clk      (clk),
      .reset    (reset),
      .rx_data  (rx_data),
      .rx_valid (rx_valid),
      .run      (run),
      .reg_wr   (reg_wr),
      .mem_wr   (mem_wr),
      .retire   (retire)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic report_unexpected(input string what);
      $display("%s: unexpected %s from the DUT", test_name, what);
      test_errors++;
   endtask

   task automatic send_byte(input logic [7:0] value);
      rx_data = value;
      rx_valid = 1'b1;
      @(negedge clk);
   endtask

   task automatic run_test(input int test, input string name);
      @(negedge clk);
      reset = 1'b1;
      phase = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      interpret(test);
      end_pc = exp_ret[$];
      test_name = name;
      test_errors = 0;
      finished = 1'b0;
      first_seen = 1'b0;
      phase = 1;
      for (int k = prog_base[test]; k < prog_base[test + 1]; k++)
      begin
         send_byte(prog_words[k][15:8]);
         send_byte(prog_words[k][7:0]);
      end
      rx_valid = 1'b0;
      phase = 2;
      run = 1'b1;
      wait (finished);
      @(negedge clk);
      run = 1'b0; // core halts before the next reset
      phase = 0;
      check_value({name, " register writes left"}, 32'd0, 32'(exp_reg.size()));
      check_value({name, " memory writes left"}, 32'd0, 32'(exp_mem.size()));
      check_value({name, " retires left"}, 32'd0, 32'(exp_ret.size()));
      if (test == 0)
         check_value({name, " first retired pc"}, 32'(PROGRAM_START), first_pc);
      $display("test %0d %s: %0d errors", test, name, test_errors);
      total_errors += test_errors;
      if (test_errors != 0)
         failed_tests++;
   endtask

   // compares every DUT strobe against the reference event lists
   always @(posedge clk)
   begin
      if (phase == 1 && (reg_wr.valid || mem_wr.valid || retire.valid))
         report_unexpected("output strobe while the program was loading");
      if (phase == 2 && !finished)
      begin
         if (reg_wr.valid)
         begin
            if (exp_reg.size() == 0)
               report_unexpected("register write");
            else
               check_value({test_name, " register write"}, exp_reg.pop_front(),
                           32'({reg_wr.index, reg_wr.value}));
         end
         if (mem_wr.valid)
         begin
            if (exp_mem.size() == 0)
               report_unexpected("memory write");
            else
               check_value({test_name, " memory write"}, exp_mem.pop_front(),
                           32'({mem_wr.addr, mem_wr.data}));
         end
         if (retire.valid)
         begin
            if (!first_seen)
               first_pc = 32'(retire.pc);
            first_seen = 1'b1;
            if (exp_ret.size() == 0)
               report_unexpected("retire");
            else
               check_value({test_name, " retired pc"}, exp_ret.pop_front(), 32'(retire.pc));
            if (32'(retire.pc) == end_pc)
               finished = 1'b1;
         end
      end
   end

   initial
   begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      rx_valid = 1'b0;
      rx_data = '0;
      run = 1'b0;
      phase = 0;
      finished = 1'b0;
      first_seen = 1'b0;
      test_errors = 0;
      total_errors = 0;
      failed_tests = 0;
      void'($urandom(63955));
      built_tests = 0;
      prog_base[0] = 0;
      build_after_reset();
      build_immediates();
      build_alu();
      build_control();
      build_memory();
      watchdog_cycles = prog_words.size() * CYCLES_PER_INSTR;
      run_test(0, "after_reset");
      run_test(1, "immediates");
      run_test(2, "alu_ops");
      run_test(3, "control_flow");
      run_test(4, "memory_transfers");
      $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests,
               total_errors);
      if (total_errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen
(
   output logic clk
);

   localparam int HALF_PERIOD = 5; // 10 ns period

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

endmodule

/* design/chip8_top.sv */
`timescale 1ns/10ps

module chip8_top import chip8_isa_pkg::*, chip8_core_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic [DATA_WIDTH-1:0] rx_data,
   input  logic                  rx_valid,
   input  logic                  run,
   output reg_wr_t               reg_wr,
   output mem_wr_t               mem_wr,
   output retire_t               retire
);

   logic [ADDR_WIDTH-1:0] mem_raddr;
   logic [DATA_WIDTH-1:0] mem_rdata;

   chip8_memory chip8_memory_i (
      .clk      (clk),
      .reset    (reset),
      .rx_data  (rx_data),
      .rx_valid (rx_valid),
      .run      (run),
      .raddr    (mem_raddr),
      .core_wr  (mem_wr),
      .rdata    (mem_rdata)
   );

   chip8_sequencer chip8_sequencer_i (
      .clk       (clk),
      .reset     (reset),
      .run       (run),
      .rdata     (mem_rdata),
      .mem_raddr (mem_raddr),
      .mem_wr    (mem_wr),
      .reg_wr    (reg_wr),
      .retire    (retire)
   );

endmodule

/* design/chip8_sequencer.sv */
`timescale 1ns/10ps

module chip8_sequencer import chip8_isa_pkg::*, chip8_core_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  run,
   input  logic [DATA_WIDTH-1:0] rdata,
   output logic [ADDR_WIDTH-1:0] mem_raddr,
   output mem_wr_t               mem_wr,
   output reg_wr_t               reg_wr,
   output retire_t               retire
);

   seq_state_e                 state, next_state;
   logic [ADDR_WIDTH-1:0]      pc, i_reg, top_addr, loop_addr;
   logic [INSTR_WIDTH-1:0]     instr_q, cur_instr;
   logic [REG_INDEX_WIDTH-1:0] loop_cnt, x_index;
   logic [DATA_WIDTH-1:0]      x_value, y_value;
   decoded_t                   dec;
   alu_result_t                alu_result;
   logic                       flag_q, flag_op, skip, loop_done, last_cycle;
   logic                       imm_we, alu_we, flag_we, load_we;

   // low byte is still on rdata during execute
   assign cur_instr = (state == ST_EXECUTE) ?
                      {instr_q[INSTR_WIDTH-1:DATA_WIDTH], rdata} : instr_q;
   assign x_index   = (state == ST_MEM_LOOP) ? loop_cnt :
                      (dec.opcode == OP_JP_V0) ? '0 : dec.x; // BNNN reads V0
   assign loop_addr = i_reg + ADDR_WIDTH'(loop_cnt);
   assign loop_done = (loop_cnt == dec.x);
   assign flag_op   = dec.alu_op inside {ALU_ADD, ALU_SUB, ALU_SHR, ALU_SUBN, ALU_SHL};
   assign skip = (dec.opcode == OP_SE_BYTE  && x_value == dec.nn) ||
                 (dec.opcode == OP_SNE_BYTE && x_value != dec.nn) ||
                 (dec.opcode == OP_SE_REG  && dec.nn[3:0] == 4'h0 && x_value == y_value) ||
                 (dec.opcode == OP_SNE_REG && dec.nn[3:0] == 4'h0 && x_value != y_value);

   instr_decoder instr_decoder_i (.instr(cur_instr), .dec(dec));

   register_file register_file_i (
      .clk(clk), .reset(reset), .wr(reg_wr),
      .x_index(x_index), .y_index(dec.y), .x_value(x_value), .y_value(y_value)
   );

   chip8_alu chip8_alu_i (.op(dec.alu_op), .vx(x_value), .vy(y_value), .result(alu_result));

   call_stack call_stack_i (
      .clk(clk), .reset(reset),
      .push(state == ST_EXECUTE && dec.opcode == OP_CALL),
      .pop(state == ST_EXECUTE && dec.is_return),
      .push_addr(pc), .top_addr(top_addr) // pc already points past the call
   );

   always_comb
   begin
      next_state = state;
      last_cycle = 1'b0;
      case (state)
         ST_IDLE:     if (run) next_state = ST_FETCH_HI;
         ST_FETCH_HI: next_state = ST_FETCH_LO;
         ST_FETCH_LO: next_state = ST_EXECUTE;
         ST_EXECUTE:
         begin
            if (flag_op)
               next_state = ST_FLAG_WRITE;
            else if (dec.is_store || dec.is_restore)
               next_state = ST_MEM_LOOP;
            else
               last_cycle = 1'b1;
         end
         ST_MEM_LOOP:
         begin
            if (loop_done && dec.is_restore)
               next_state = ST_MEM_WAIT; // last byte still in flight
            else if (loop_done)
               last_cycle = 1'b1;
         end
         default:     last_cycle = 1'b1; // flag write, mem wait
      endcase
      if (last_cycle)
         next_state = run ? ST_FETCH_HI : ST_IDLE;
   end

   always_comb
   begin
      case (state)
         ST_FETCH_LO: mem_raddr = pc + ADDR_WIDTH'(1);
         ST_MEM_LOOP: mem_raddr = loop_addr;
         default:     mem_raddr = pc;
      endcase
   end

   assign imm_we  = (state == ST_EXECUTE) &&
                    (dec.opcode == OP_LD_BYTE || dec.opcode == OP_ADD_BYTE);
   assign alu_we  = (state == ST_EXECUTE) && (dec.alu_op != ALU_NONE);
   assign flag_we = (state == ST_FLAG_WRITE);
   assign load_we = (state == ST_MEM_LOOP && dec.is_restore && loop_cnt != '0) ||
                    (state == ST_MEM_WAIT);

   always_comb
   begin
      reg_wr.valid = imm_we | alu_we | flag_we | load_we;
      reg_wr.index = dec.x;
      reg_wr.value = rdata;
      if (imm_we)
         reg_wr.value = (dec.opcode == OP_LD_BYTE) ? dec.nn : x_value + dec.nn;
      else if (alu_we)
         reg_wr.value = alu_result.value;
      else if (flag_we)
      begin
         reg_wr.index = FLAG_REG;
         reg_wr.value = DATA_WIDTH'(flag_q);
      end
      else if (load_we)
         reg_wr.index = (state == ST_MEM_WAIT) ? loop_cnt : loop_cnt - 1'b1; // one behind
   end

   assign mem_wr = '{valid: state == ST_MEM_LOOP && dec.is_store, addr: loop_addr,
                     data: x_value};
   assign retire = '{valid: last_cycle, pc: pc - ADDR_WIDTH'(2)};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= ST_IDLE;
         pc       <= PROGRAM_START;
         i_reg    <= '0;
         loop_cnt <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == ST_FETCH_LO)
            pc <= pc + ADDR_WIDTH'(2);
         else if (state == ST_EXECUTE)
         begin
            case (dec.opcode)
               OP_SYS:         if (dec.is_return) pc <= top_addr;
               OP_JP, OP_CALL: pc <= dec.nnn;
               OP_JP_V0:       pc <= dec.nnn + ADDR_WIDTH'(x_value);
               default:        if (skip) pc <= pc + ADDR_WIDTH'(2);
            endcase
            if (dec.opcode == OP_LD_I)
               i_reg <= dec.nnn;
            else if (dec.is_add_i)
               i_reg <= i_reg + ADDR_WIDTH'(x_value);
            loop_cnt <= '0;
         end
         else if (state == ST_MEM_LOOP && !loop_done)
            loop_cnt <= loop_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_FETCH_LO)
         instr_q[INSTR_WIDTH-1:DATA_WIDTH] <= rdata;
      if (state == ST_EXECUTE)
      begin
         instr_q[DATA_WIDTH-1:0] <= rdata;
         flag_q <= alu_result.flag; // vx may be overwritten before vf
      end
   end

   one_reg_write: assert property (
      @(posedge clk) disable iff (reset) $onehot0({imm_we, alu_we, flag_we, load_we})
   );

endmodule

/* design/call_stack.sv */
`timescale 1ns/10ps

module call_stack import chip8_isa_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  push,
   input  logic                  pop,
   input  logic [ADDR_WIDTH-1:0] push_addr,
   output logic [ADDR_WIDTH-1:0] top_addr
);

   logic [ADDR_WIDTH-1:0]            entries [STACK_DEPTH];
   logic [$clog2(STACK_DEPTH):0]     depth; // one extra bit for full
   logic [$clog2(STACK_DEPTH)-1:0]   top_index;

   assign top_index = depth[$clog2(STACK_DEPTH)-1:0] - 1'b1;
   assign top_addr  = entries[top_index];

   always_ff @(posedge clk)
   begin
      if (reset)
         depth <= '0;
      else if (push)
         depth <= depth + 1'b1;
      else if (pop)
         depth <= depth - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (push)
         entries[depth[$clog2(STACK_DEPTH)-1:0]] <= push_addr;
   end

   no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> depth != STACK_DEPTH);
   no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> depth != 0);

endmodule

/* design/chip8_alu.sv */
`timescale 1ns/10ps

module chip8_alu import chip8_isa_pkg::*, chip8_core_pkg::*;
(
   input  alu_op_e               op,
   input  logic [DATA_WIDTH-1:0] vx,
   input  logic [DATA_WIDTH-1:0] vy,
   output alu_result_t           result
);

   logic [DATA_WIDTH:0] sum;

   assign sum = {1'b0, vx} + {1'b0, vy};

   always_comb
   begin
      result.value = vx;
      result.flag  = 1'b0;
      case (op)
         ALU_LD:  result.value = vy;
         ALU_OR:  result.value = vx | vy;
         ALU_AND: result.value = vx & vy;
         ALU_XOR: result.value = vx ^ vy;
         ALU_ADD:
         begin
            result.value = sum[DATA_WIDTH-1:0];
            result.flag  = sum[DATA_WIDTH]; // carry out
         end
         ALU_SUB:
         begin
            result.value = vx - vy;
            result.flag  = (vx >= vy); // no borrow
         end
         ALU_SHR:
         begin
            result.value = vx >> 1;
            result.flag  = vx[0];
         end
         ALU_SUBN:
         begin
            result.value = vy - vx;
            result.flag  = (vy >= vx);
         end
         ALU_SHL:
         begin
            result.value = vx << 1;
            result.flag  = vx[DATA_WIDTH-1];
         end
         default: ; // none passes vx
      endcase
   end

endmodule

/* design/register_file.sv */
`timescale 1ns/10ps

module register_file import chip8_isa_pkg::*, chip8_core_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  reg_wr_t                    wr,
   input  logic [REG_INDEX_WIDTH-1:0] x_index,
   input  logic [REG_INDEX_WIDTH-1:0] y_index,
   output logic [DATA_WIDTH-1:0]      x_value,
   output logic [DATA_WIDTH-1:0]      y_value
);

   logic [DATA_WIDTH-1:0] regs [2**REG_INDEX_WIDTH]; // V0..VF

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**REG_INDEX_WIDTH; i++)
            regs[i] <= '0;
      end
      else if (wr.valid)
      begin
         regs[wr.index] <= wr.value;
      end
   end

   assign x_value = regs[x_index];
   assign y_value = regs[y_index];

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder import chip8_isa_pkg::*, chip8_core_pkg::*;
(
   input  logic [INSTR_WIDTH-1:0] instr,
   output decoded_t               dec
);

   opcode_e opcode;
   alu_op_e alu_op;

   assign opcode = opcode_e'(instr[15:12]);

   always_comb
   begin
      alu_op = ALU_NONE;
      if (opcode == OP_ALU)
      begin
         case (instr[3:0])
            4'h0:    alu_op = ALU_LD;
            4'h1:    alu_op = ALU_OR;
            4'h2:    alu_op = ALU_AND;
            4'h3:    alu_op = ALU_XOR;
            4'h4:    alu_op = ALU_ADD;
            4'h5:    alu_op = ALU_SUB;
            4'h6:    alu_op = ALU_SHR;
            4'h7:    alu_op = ALU_SUBN;
            4'hE:    alu_op = ALU_SHL;
            default: alu_op = ALU_NONE; // undefined 8XY_ is a nop
         endcase
      end
   end

   always_comb
   begin
      dec.opcode     = opcode;
      dec.alu_op     = alu_op;
      dec.x          = instr[11:8];
      dec.y          = instr[7:4];
      dec.nn         = instr[7:0];
      dec.nnn        = instr[11:0];
      dec.is_return  = (instr == 16'h00EE);
      dec.is_add_i   = (opcode == OP_MISC) && (instr[7:0] == 8'h1E);
      dec.is_store   = (opcode == OP_MISC) && (instr[7:0] == 8'h55);
      dec.is_restore = (opcode == OP_MISC) && (instr[7:0] == 8'h65);
   end

endmodule

/* design/chip8_memory.sv */
`timescale 1ns/10ps

module chip8_memory import chip8_isa_pkg::*, chip8_core_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic [DATA_WIDTH-1:0] rx_data,
   input  logic                  rx_valid,
   input  logic                  run,
   input  logic [ADDR_WIDTH-1:0] raddr,
   input  mem_wr_t               core_wr,
   output logic [DATA_WIDTH-1:0] rdata
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
   logic [ADDR_WIDTH-1:0] load_addr;

   always_ff @(posedge clk)
   begin
      if (reset)
         load_addr <= PROGRAM_START;
      else if (rx_valid)
         load_addr <= load_addr + ADDR_WIDTH'(1);
   end

   // loader owns the write port while run is low
   always_ff @(posedge clk)
   begin
      if (rx_valid && !run)
         mem[load_addr] <= rx_data;
      else if (run && core_wr.valid)
         mem[core_wr.addr] <= core_wr.data; // FX55 stores
      rdata <= mem[raddr];
   end

   // program bytes may only arrive while the core is stopped
   rx_while_stopped: assert property (
      @(posedge clk) disable iff (reset) rx_valid |-> !run
   );

endmodule

/* design/chip8_core_pkg.sv */
package chip8_core_pkg;

   import chip8_isa_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FETCH_HI,
      ST_FETCH_LO,
      ST_EXECUTE,
      ST_FLAG_WRITE,
      ST_MEM_LOOP,
      ST_MEM_WAIT
   } seq_state_e;

   typedef struct packed {
      opcode_e                    opcode;
      alu_op_e                    alu_op;
      logic [REG_INDEX_WIDTH-1:0] x;
      logic [REG_INDEX_WIDTH-1:0] y;
      logic [DATA_WIDTH-1:0]      nn;
      logic [ADDR_WIDTH-1:0]      nnn;
      logic                       is_return;  // 00EE
      logic                       is_add_i;   // FX1E
      logic                       is_store;   // FX55
      logic                       is_restore; // FX65
   } decoded_t;

   typedef struct packed {
      logic                       valid;
      logic [REG_INDEX_WIDTH-1:0] index;
      logic [DATA_WIDTH-1:0]      value;
   } reg_wr_t;

   typedef struct packed {
      logic                  valid;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
   } mem_wr_t;

   typedef struct packed {
      logic                  valid;
      logic [ADDR_WIDTH-1:0] pc;
   } retire_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] value;
      logic                  flag;
   } alu_result_t;

endpackage

/* design/chip8_isa_pkg.sv */
package chip8_isa_pkg;

   localparam int ADDR_WIDTH      = 12;
   localparam int DATA_WIDTH      = 8;
   localparam int INSTR_WIDTH     = 16;
   localparam int REG_INDEX_WIDTH = 4;
   localparam int STACK_DEPTH     = 16;

   localparam logic [ADDR_WIDTH-1:0]      PROGRAM_START = 12'h200;
   localparam logic [REG_INDEX_WIDTH-1:0] FLAG_REG      = 4'hF; // vf

   // top nibble of the instruction
   typedef enum logic [3:0] {
      OP_SYS      = 4'h0,
      OP_JP       = 4'h1,
      OP_CALL     = 4'h2,
      OP_SE_BYTE  = 4'h3,
      OP_SNE_BYTE = 4'h4,
      OP_SE_REG   = 4'h5,
      OP_LD_BYTE  = 4'h6,
      OP_ADD_BYTE = 4'h7,
      OP_ALU      = 4'h8,
      OP_SNE_REG  = 4'h9,
      OP_LD_I     = 4'hA,
      OP_JP_V0    = 4'hB,
      OP_RND      = 4'hC,
      OP_DRW      = 4'hD,
      OP_SKP      = 4'hE,
      OP_MISC     = 4'hF
   } opcode_e;

   // values follow the low nibble of 8XY_
   typedef enum logic [3:0] {
      ALU_LD   = 4'h0,
      ALU_OR   = 4'h1,
      ALU_AND  = 4'h2,
      ALU_XOR  = 4'h3,
      ALU_ADD  = 4'h4,
      ALU_SUB  = 4'h5,
      ALU_SHR  = 4'h6,
      ALU_SUBN = 4'h7,
      ALU_SHL  = 4'hE,
      ALU_NONE = 4'hF
   } alu_op_e;

endpackage
